/* hdl/mem_bridge_cfg.svh */
`ifndef MEM_BRIDGE_CFG_SVH
`define MEM_BRIDGE_CFG_SVH

// request slots, ids are log2 of this
`define MB_SLOTS 16

// one full host line per slot
`define MB_LINE_BITS 512

// local addresses are signed and get sign-extended onto the host base
`define MB_LADDR_BITS 36
`define MB_HADDR_BITS 64

`endif

/* hdl/req_pkg.sv */
`include "mem_bridge_cfg.svh"

package req_pkg;

  // requester packet encodings
  typedef enum logic [2:0] {
    pkt_none   = 3'd0,
    pkt_wr_req = 3'd1,
    pkt_rd_req = 3'd3,
    pkt_wr_cpl = 3'd5,
    pkt_rd_cpl = 3'd6
  } pkt_type_e;

  typedef logic [$clog2(`MB_SLOTS)-1:0] slot_id_t;

  // signed so it can reach below the host base
  typedef logic signed [`MB_LADDR_BITS-1:0] laddr_t;

endpackage

/* hdl/host_pkg.sv */
`include "mem_bridge_cfg.svh"

package host_pkg;

  // byte address on the host memory port
  typedef logic [`MB_HADDR_BITS-1:0] haddr_t;

  // one host line
  typedef logic [`MB_LINE_BITS-1:0] line_t;

endpackage

/* hdl/slot_if.sv */
`timescale 1ns/1ps

interface slot_if import req_pkg::*, host_pkg::*; ();

  // engine side, selects a slot and strobes updates into it
  slot_id_t sel;
  logic     fill;
  line_t    fill_data;
  logic     mark;
  logic     release_slot;

  // table side, status of the selected slot
  logic     is_read;
  logic     is_write;
  logic     has_data;
  logic     written;
  laddr_t   addr;
  line_t    data;

  modport tbl (
    input  sel, fill, fill_data, mark, release_slot,
    output is_read, is_write, has_data, written, addr, data
  );

  modport engine (
    output sel, fill, fill_data, mark, release_slot,
    input  is_read, is_write, has_data, written, addr, data
  );

endinterface

/* hdl/slot_table.sv */
`timescale 1ns/1ps
`include "mem_bridge_cfg.svh"

module slot_table import req_pkg::*, host_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  pkt_type_e req_type,
  input  slot_id_t  req_id,
  input  laddr_t    req_addr,
  input  line_t     req_data,
  slot_if.tbl       rd_port,
  slot_if.tbl       wr_port,
  slot_if.tbl       wb_port
);

  laddr_t slot_addr [`MB_SLOTS];
  line_t  slot_data [`MB_SLOTS];

  logic [`MB_SLOTS-1:0] is_read_q;
  logic [`MB_SLOTS-1:0] is_write_q;
  logic [`MB_SLOTS-1:0] has_data_q;
  logic [`MB_SLOTS-1:0] written_q;

  logic [`MB_SLOTS-1:0] rel_hit;
  logic [`MB_SLOTS-1:0] fill_hit;
  logic [`MB_SLOTS-1:0] mark_hit;
  logic [`MB_SLOTS-1:0] req_hit;

  // per-slot update decode, priority is release, fill, mark, request
  // read engine fills, write engine marks, writeback engine releases
  always_comb begin
    for (int i = 0; i < `MB_SLOTS; i++) begin
      rel_hit[i]  = wb_port.release_slot && wb_port.sel == slot_id_t'(i);
      fill_hit[i] = rd_port.fill && rd_port.sel == slot_id_t'(i);
      mark_hit[i] = wr_port.mark && wr_port.sel == slot_id_t'(i);
      req_hit[i]  = !rel_hit[i] && !fill_hit[i] && !mark_hit[i] &&
                    req_id == slot_id_t'(i);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      is_read_q  <= '0;
      is_write_q <= '0;
      has_data_q <= '0;
      written_q  <= '0;
    end else begin
      for (int i = 0; i < `MB_SLOTS; i++) begin
        if (rel_hit[i]) begin
          is_read_q[i]  <= 1'b0;
          is_write_q[i] <= 1'b0;
          has_data_q[i] <= 1'b0;
          written_q[i]  <= 1'b0;
        end else if (fill_hit[i]) begin
          has_data_q[i] <= 1'b1;
        end else if (mark_hit[i]) begin
          written_q[i] <= 1'b1;
        end else if (req_hit[i] && req_type != pkt_none) begin
          // a new request replaces whatever the slot held
          is_read_q[i]  <= req_type == pkt_rd_req;
          is_write_q[i] <= req_type == pkt_wr_req;
          has_data_q[i] <= req_type == pkt_wr_req;
          written_q[i]  <= 1'b0;
        end
      end
    end
  end

  // address and line storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MB_SLOTS; i++) begin
      if (!rel_hit[i] && fill_hit[i]) begin
        slot_data[i] <= rd_port.fill_data;
      end else if (req_hit[i] && req_type == pkt_wr_req) begin
        slot_addr[i] <= req_addr;
        slot_data[i] <= req_data;
      end else if (req_hit[i] && req_type == pkt_rd_req) begin
        slot_addr[i] <= req_addr;
      end
    end
  end

  assign rd_port.is_read  = is_read_q[rd_port.sel];
  assign rd_port.is_write = is_write_q[rd_port.sel];
  assign rd_port.has_data = has_data_q[rd_port.sel];
  assign rd_port.written  = written_q[rd_port.sel];
  assign rd_port.addr     = slot_addr[rd_port.sel];
  assign rd_port.data     = slot_data[rd_port.sel];

  assign wr_port.is_read  = is_read_q[wr_port.sel];
  assign wr_port.is_write = is_write_q[wr_port.sel];
  assign wr_port.has_data = has_data_q[wr_port.sel];
  assign wr_port.written  = written_q[wr_port.sel];
  assign wr_port.addr     = slot_addr[wr_port.sel];
  assign wr_port.data     = slot_data[wr_port.sel];

  assign wb_port.is_read  = is_read_q[wb_port.sel];
  assign wb_port.is_write = is_write_q[wb_port.sel];
  assign wb_port.has_data = has_data_q[wb_port.sel];
  assign wb_port.written  = written_q[wb_port.sel];
  assign wb_port.addr     = slot_addr[wb_port.sel];
  assign wb_port.data     = slot_data[wb_port.sel];

endmodule

/* hdl/host_read_engine.sv */
`timescale 1ns/1ps
`include "mem_bridge_cfg.svh"

module host_read_engine import req_pkg::*, host_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  haddr_t base_addr,
  slot_if.engine slots,
  output logic   rd_go,
  output logic   rd_en,
  output haddr_t rd_addr,
  input  line_t  rd_data,
  input  logic   rd_empty,
  input  logic   rd_done
);

  typedef enum logic {st_idle, st_busy} state_e;

  state_e   state;
  slot_id_t scan_idx;
  logic     captured;

  assign slots.sel          = scan_idx;
  assign slots.mark         = 1'b0;
  assign slots.release_slot = 1'b0;

  // start on a pending read that has no line yet
  assign rd_go   = state == st_idle && slots.is_read && !slots.has_data;
  assign rd_addr = base_addr +
                   {{(`MB_HADDR_BITS - `MB_LADDR_BITS){slots.addr[`MB_LADDR_BITS-1]}},
                    slots.addr};

  // first word seen fills the slot, only once per transaction
  assign slots.fill      = state == st_busy && !rd_empty && !captured;
  assign slots.fill_data = rd_data;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= st_idle;
      scan_idx <= '0;
      captured <= 1'b0;
      rd_en    <= 1'b0;
    end else begin
      // pop the captured word one cycle after the fill
      rd_en <= slots.fill;
      case (state)
        st_idle: begin
          if (rd_go) begin
            state <= st_busy;
          end else begin
            scan_idx <= scan_idx + 1'b1;
          end
        end
        st_busy: begin
          if (slots.fill) begin
            captured <= 1'b1;
          end
          if (rd_done) begin
            state    <= st_idle;
            captured <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* hdl/host_write_engine.sv */
`timescale 1ns/1ps
`include "mem_bridge_cfg.svh"

module host_write_engine import req_pkg::*, host_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  haddr_t base_addr,
  slot_if.engine slots,
  output logic   wr_go,
  output logic   wr_en,
  output haddr_t wr_addr,
  output line_t  wr_data,
  input  logic   wr_full,
  input  logic   wr_done
);

  typedef enum logic {st_idle, st_busy} state_e;

  state_e   state;
  slot_id_t scan_idx;
  logic     accepted;

  assign slots.sel          = scan_idx;
  assign slots.fill         = 1'b0;
  assign slots.fill_data    = '0;
  assign slots.release_slot = 1'b0;

  assign wr_go   = state == st_idle && slots.is_write && slots.has_data && !slots.written;
  assign wr_addr = base_addr +
                   {{(`MB_HADDR_BITS - `MB_LADDR_BITS){slots.addr[`MB_LADDR_BITS-1]}},
                    slots.addr};
  assign wr_data = slots.data;

  // offer the line until the host takes it once
  assign wr_en      = state == st_busy && !wr_full && !accepted;
  assign slots.mark = state == st_busy && wr_done;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= st_idle;
      scan_idx <= '0;
      accepted <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (wr_go) begin
            state <= st_busy;
          end else begin
            scan_idx <= scan_idx + 1'b1;
          end
        end
        st_busy: begin
          if (wr_en) begin
            accepted <= 1'b1;
          end
          if (wr_done) begin
            state    <= st_idle;
            accepted <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* hdl/writeback_engine.sv */
`timescale 1ns/1ps

module writeback_engine import req_pkg::*, host_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  slot_if.engine    slots,
  output pkt_type_e resp_type,
  output slot_id_t  resp_id,
  output laddr_t    resp_addr,
  output line_t     resp_data
);

  slot_id_t scan_idx;
  logic     wr_finished;
  logic     rd_finished;

  assign slots.sel       = scan_idx;
  assign slots.fill      = 1'b0;
  assign slots.fill_data = '0;
  assign slots.mark      = 1'b0;

  assign wr_finished = slots.is_write && slots.written;
  assign rd_finished = slots.is_read && slots.has_data;

  // completion goes out in the same cycle the scan lands on it
  always_comb begin
    if (wr_finished) begin
      resp_type = pkt_wr_cpl;
    end else if (rd_finished) begin
      resp_type = pkt_rd_cpl;
    end else begin
      resp_type = pkt_none;
    end
  end

  assign resp_id   = scan_idx;
  assign resp_addr = slots.addr;
  // only read completions carry the line
  assign resp_data = rd_finished ? slots.data : '0;

  // slot is freed at the edge that ends the completion cycle
  assign slots.release_slot = wr_finished || rd_finished;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      scan_idx <= '0;
    end else begin
      scan_idx <= scan_idx + 1'b1;
    end
  end

endmodule

/* hdl/mem_bridge_top.sv */
`timescale 1ns/1ps

module mem_bridge_top import req_pkg::*, host_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // requester side
  input  pkt_type_e req_type,
  input  slot_id_t  req_id,
  input  laddr_t    req_addr,
  input  line_t     req_data,

  input  haddr_t    base_addr,

  // host read port
  output logic      rd_go,
  output haddr_t    rd_addr,
  output logic      rd_en,
  input  line_t     rd_data,
  input  logic      rd_empty,
  input  logic      rd_done,

  // host write port
  output logic      wr_go,
  output haddr_t    wr_addr,
  output line_t     wr_data,
  output logic      wr_en,
  input  logic      wr_full,
  input  logic      wr_done,

  // completions
  output pkt_type_e resp_type,
  output slot_id_t  resp_id,
  output laddr_t    resp_addr,
  output line_t     resp_data
);

  slot_if rd_slot ();
  slot_if wr_slot ();
  slot_if wb_slot ();

  slot_table slot_table_i (
    .clk      (clk),
    .rst      (rst),
    .req_type (req_type),
    .req_id   (req_id),
    .req_addr (req_addr),
    .req_data (req_data),
    .rd_port  (rd_slot.tbl),
    .wr_port  (wr_slot.tbl),
    .wb_port  (wb_slot.tbl)
  );

  host_read_engine host_read_engine_i (
    .clk       (clk),
    .rst       (rst),
    .base_addr (base_addr),
    .slots     (rd_slot.engine),
    .rd_go     (rd_go),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .rd_empty  (rd_empty),
    .rd_done   (rd_done)
  );

  host_write_engine host_write_engine_i (
    .clk       (clk),
    .rst       (rst),
    .base_addr (base_addr),
    .slots     (wr_slot.engine),
    .wr_go     (wr_go),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_full   (wr_full),
    .wr_done   (wr_done)
  );

  writeback_engine writeback_engine_i (
    .clk       (clk),
    .rst       (rst),
    .slots     (wb_slot.engine),
    .resp_type (resp_type),
    .resp_id   (resp_id),
    .resp_addr (resp_addr),
    .resp_data (resp_data)
  );

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* verification/mem_bridge_checker.sv */
`timescale 1ns/1ps
`include "mem_bridge_cfg.svh"

module mem_bridge_checker import req_pkg::*, host_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  pkt_type_e req_type,
  input  slot_id_t  req_id,
  input  laddr_t    req_addr,
  input  line_t     req_data,
  input  haddr_t    base_addr,
  input  logic      rd_go,
  input  logic      rd_en,
  input  haddr_t    rd_addr,
  input  logic      rd_done,
  input  logic      wr_go,
  input  logic      wr_en,
  input  haddr_t    wr_addr,
  input  line_t     wr_data,
  input  logic      wr_done,
  input  pkt_type_e resp_type,
  input  slot_id_t  resp_id,
  input  laddr_t    resp_addr,
  input  line_t     resp_data,
  input  logic      show_counts,
  output int        errors,
  output int        completions
);

  // one expected entry per slot id
  logic [`MB_SLOTS-1:0] pending;
  logic [`MB_SLOTS-1:0] started;
  pkt_type_e exp_kind  [`MB_SLOTS];
  laddr_t    exp_laddr [`MB_SLOTS];
  haddr_t    exp_haddr [`MB_SLOTS];
  line_t     exp_line  [`MB_SLOTS];

  // lines that completed writes left in host memory
  line_t ref_mem [haddr_t];
  logic  rd_open;
  logic  wr_open;

  initial begin
    errors      = 0;
    completions = 0;
  end

  function automatic haddr_t host_addr_of(haddr_t base, laddr_t offset);
    longint wide;
    wide = offset;
    return base + haddr_t'(wide);
  endfunction

  function automatic int find_start(pkt_type_e kind, haddr_t addr);
    for (int i = 0; i < `MB_SLOTS; i++) begin
      if (pending[i] && !started[i] && exp_kind[i] == kind && exp_haddr[i] == addr) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic report_mismatch(input string name, input int id, input line_t got,
                                 input line_t want);
    $display("MISMATCH %s id %0d: got 0x%0h, expected 0x%0h", name, id, got, want);
    errors++;
  endtask

  task automatic check_completion(input int id);
    int     errors_before;
    haddr_t haddr;
    line_t  want_line;
    errors_before = errors;
    haddr = exp_haddr[id];
    if (exp_kind[id] == pkt_wr_req) begin
      if (resp_type !== pkt_wr_cpl) begin
        report_mismatch("resp_type", id, resp_type, pkt_wr_cpl);
      end
      ref_mem[haddr] = exp_line[id];
    end else begin
      // never written lines come back as the address repeated
      want_line = ref_mem.exists(haddr) ? ref_mem[haddr] :
                  {(`MB_LINE_BITS / `MB_HADDR_BITS){haddr}};
      if (resp_type !== pkt_rd_cpl) begin
        report_mismatch("resp_type", id, resp_type, pkt_rd_cpl);
      end
      if (resp_data !== want_line) begin
        report_mismatch("resp_data", id, resp_data, want_line);
      end
    end
    if (resp_addr !== exp_laddr[id]) begin
      report_mismatch("resp_addr", id, $unsigned(resp_addr), $unsigned(exp_laddr[id]));
    end
    if (!started[id]) begin
      report_error($sformatf("id %0d completed without a host transaction", id));
    end
    pending[id] = 1'b0;
    $display("row done: id %0d %s at 0x%0h, %s", id, resp_type.name(), $unsigned(resp_addr),
             errors == errors_before ? "ok" : "bad");
    completions <= completions + 1;
  endtask

  always @(posedge clk) begin
    int id;
    if (rst) begin
      pending = '0;
      started = '0;
      rd_open = 1'b0;
      wr_open = 1'b0;
    end else begin
      if ($isunknown({rd_go, rd_en, wr_go, wr_en, resp_type})) begin
        report_error("host strobes or resp_type are unknown");
      end
      if (rd_go) begin
        id = find_start(pkt_rd_req, rd_addr);
        if (id < 0) begin
          report_error($sformatf("rd_go at 0x%0h matches no pending read", rd_addr));
        end else begin
          started[id] = 1'b1;
        end
        rd_open = 1'b1;
      end
      if (rd_en && !rd_open) begin
        report_error("rd_en pulsed with no host read open");
      end
      if (rd_done) begin
        rd_open = 1'b0;
      end
      if (wr_go) begin
        id = find_start(pkt_wr_req, wr_addr);
        if (id < 0) begin
          report_error($sformatf("wr_go at 0x%0h matches no pending write", wr_addr));
        end else begin
          started[id] = 1'b1;
          if (wr_data !== exp_line[id]) begin
            report_mismatch("wr_data", id, wr_data, exp_line[id]);
          end
        end
        wr_open = 1'b1;
      end
      if (wr_en && !wr_open) begin
        report_error("wr_en raised with no host write open");
      end
      if (wr_done) begin
        wr_open = 1'b0;
      end
      if (resp_type != pkt_none) begin
        id = resp_id;
        if (!pending[id]) begin
          report_error($sformatf("completion on id %0d with no pending request", id));
        end else begin
          check_completion(id);
        end
      end
      if (req_type != pkt_none) begin
        pending[req_id]   = 1'b1;
        started[req_id]   = 1'b0;
        exp_kind[req_id]  = req_type;
        exp_laddr[req_id] = req_addr;
        exp_haddr[req_id] = host_addr_of(base_addr, req_addr);
        exp_line[req_id]  = req_data;
      end
    end
  end

  always @(posedge show_counts) begin
    $display("summary: %0d completions, %0d errors", completions, errors);
  end

endmodule

/* verification/mem_bridge_tb.sv */
`timescale 1ns/1ps
`include "mem_bridge_cfg.svh"

module mem_bridge_tb import req_pkg::*, host_pkg::*; ();

  localparam int     num_rows     = 13;
  localparam int     reset_cycles = 8;
  localparam int     idle_cycles  = 24;
  localparam int     drain_cycles = 20;
  // 64 cycles per row on top of reset, the idle check and the final drain
  localparam int     cycle_limit  = num_rows * 64 + reset_cycles + idle_cycles + drain_cycles;
  localparam haddr_t table_base   = 64'h0000_0100_0000_0000;

  typedef struct {
    pkt_type_e kind;
    slot_id_t  id;
    laddr_t    addr;
    line_t     line;
    logic      wait_all;
  } row_t;

  row_t rows [num_rows];

  logic      clk;
  logic      rst;
  pkt_type_e req_type;
  slot_id_t  req_id;
  laddr_t    req_addr;
  line_t     req_data;
  haddr_t    base_addr;
  logic      rd_go;
  haddr_t    rd_addr;
  logic      rd_en;
  line_t     rd_data;
  logic      rd_empty;
  logic      rd_done;
  logic      wr_go;
  haddr_t    wr_addr;
  line_t     wr_data;
  logic      wr_en;
  logic      wr_full;
  logic      wr_done;
  pkt_type_e resp_type;
  slot_id_t  resp_id;
  laddr_t    resp_addr;
  line_t     resp_data;

  logic      show_counts;
  int        errors;
  int        completions;
  int        issued;

  // host memory model state
  line_t     host_mem [haddr_t];
  int        rd_delay;
  int        wr_delay;
  logic      wr_pending;

  tb_clk_gen #(.reset_cycles(reset_cycles)) clk_gen_i (
    .clk (clk),
    .rst (rst)
  );

  mem_bridge_top mem_bridge_top_i (.*);

  mem_bridge_checker check_i (.*);

  // every 32-bit word depends on the tag and its position
  function automatic line_t pattern(logic [31:0] tag);
    line_t line;
    for (int w = 0; w < `MB_LINE_BITS / 32; w++) begin
      line[w*32 +: 32] = tag ^ (w * 32'h0101_0101);
    end
    return line;
  endfunction

  task automatic set_row(input int idx, input pkt_type_e kind, input slot_id_t id,
                         input laddr_t addr, input line_t line, input logic wait_all);
    rows[idx].kind     = kind;
    rows[idx].id       = id;
    rows[idx].addr     = addr;
    rows[idx].line     = line;
    rows[idx].wait_all = wait_all;
  endtask

  task automatic load_rows();
    set_row(0,  pkt_wr_req, 4'd1,  36'h0_0000_0100, pattern(32'h1111_a5a5), 1'b1);
    set_row(1,  pkt_rd_req, 4'd2,  36'h0_0000_0800, '0,                     1'b1);
    set_row(2,  pkt_rd_req, 4'd3,  36'h0_0000_0100, '0,                     1'b1);
    // negative offsets land below the base
    set_row(3,  pkt_wr_req, 4'd4,  36'hf_ffff_ffc0, pattern(32'h2222_5a5a), 1'b1);
    set_row(4,  pkt_rd_req, 4'd5,  36'hf_ffff_ffc0, '0,                     1'b1);
    set_row(5,  pkt_rd_req, 4'd6,  36'hf_ffff_f000, '0,                     1'b1);
    // several outstanding ids against host back-pressure
    set_row(6,  pkt_wr_req, 4'd7,  36'h0_0000_0200, pattern(32'h3333_0f0f), 1'b0);
    set_row(7,  pkt_rd_req, 4'd8,  36'h0_0000_0300, '0,                     1'b0);
    set_row(8,  pkt_wr_req, 4'd9,  36'h0_0000_0400, pattern(32'h4444_f0f0), 1'b0);
    set_row(9,  pkt_rd_req, 4'd10, 36'h0_0000_0100, '0,                     1'b0);
    set_row(10, pkt_wr_req, 4'd11, 36'h0_0000_0500, pattern(32'h5555_3c3c), 1'b0);
    set_row(11, pkt_rd_req, 4'd12, 36'h8_0000_0000, '0,                     1'b1);
    set_row(12, pkt_rd_req, 4'd13, 36'h0_0000_0200, '0,                     1'b1);
  endtask

  initial begin
    req_type    = pkt_none;
    req_id      = '0;
    req_addr    = '0;
    req_data    = '0;
    base_addr   = table_base;
    show_counts = 1'b0;
    issued      = 0;
    load_rows();
    while (rst !== 1'b0) @(posedge clk);
    // quiet period, nothing may move without a request
    repeat (idle_cycles) @(posedge clk);
    for (int r = 0; r < num_rows; r++) begin
      req_type <= rows[r].kind;
      req_id   <= rows[r].id;
      req_addr <= rows[r].addr;
      req_data <= rows[r].line;
      @(posedge clk);
      req_type <= pkt_none;
      issued++;
      if (rows[r].wait_all) begin
        while (completions < issued) @(posedge clk);
      end
      @(posedge clk);
    end
    while (completions < issued) @(posedge clk);
    // late completions from released slots would show up here
    repeat (drain_cycles) @(posedge clk);
    show_counts <= 1'b1;
    @(posedge clk);
    if (errors == 0 && completions == issued) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // host memory port model
  initial begin
    rd_data    = '0;
    rd_empty   = 1'b1;
    rd_done    = 1'b0;
    wr_full    = 1'b1;
    wr_done    = 1'b0;
    rd_delay   = 0;
    wr_delay   = 0;
    wr_pending = 1'b0;
    void'($urandom(32'h865f));
    forever begin
      @(posedge clk);
      rd_done    <= 1'b0;
      wr_done    <= wr_pending;
      wr_pending <= wr_en && !wr_full;
      if (rd_go) begin
        rd_data  <= host_mem.exists(rd_addr) ? host_mem[rd_addr] :
                    {(`MB_LINE_BITS / `MB_HADDR_BITS){rd_addr}};
        rd_delay = $urandom % 4;
        rd_empty <= rd_delay != 0;
      end else if (rd_en) begin
        rd_empty <= 1'b1;
        rd_done  <= 1'b1;
      end else if (rd_delay > 0) begin
        rd_delay = rd_delay - 1;
        if (rd_delay == 0) begin
          rd_empty <= 1'b0;
        end
      end
      if (wr_go) begin
        wr_delay = $urandom % 4;
        wr_full  <= wr_delay != 0;
      end else if (wr_en && !wr_full) begin
        host_mem[wr_addr] = wr_data;
        wr_full <= 1'b1;
      end else if (wr_delay > 0) begin
        wr_delay = wr_delay - 1;
        if (wr_delay == 0) begin
          wr_full <= 1'b0;
        end
      end
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d of %0d requests completed",
             cycles, completions, issued);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hdl
hdl/req_pkg.sv
hdl/host_pkg.sv
hdl/slot_if.sv
hdl/slot_table.sv
hdl/host_read_engine.sv
hdl/host_write_engine.sv
hdl/writeback_engine.sv
hdl/mem_bridge_top.sv
verification/tb_clk_gen.sv
verification/mem_bridge_checker.sv
verification/mem_bridge_tb.sv

/* Bender.yml */
package:
  name: mem_bridge

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/req_pkg.sv
      - hdl/host_pkg.sv
      - hdl/slot_if.sv
      - hdl/slot_table.sv
      - hdl/host_read_engine.sv
      - hdl/host_write_engine.sv
      - hdl/writeback_engine.sv
      - hdl/mem_bridge_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_clk_gen.sv
      - verification/mem_bridge_checker.sv
      - verification/mem_bridge_tb.sv
